// File: flist.f
+incdir+.
muldiv_pkg.sv
int_mul_iterative.sv
int_div_iterative.sv
muldiv_router.sv
muldiv_top.sv
muldiv_checker.sv
tb_muldiv.sv

// File: int_div_iterative.sv
//----------------------------------------------------------------------------
// iterative restoring divider
// signed or unsigned, magnitude division with sign fix and divide-by-zero rule
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic [`MULDIV_XLEN-1:0]    req_a,
  input  logic [`MULDIV_XLEN-1:0]    req_b,
  input  logic                       div_signed,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_t resp_result
);

  import muldiv_pkg::*;

  localparam int CNT_W = $clog2(`MULDIV_ITERS);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  // control
  state_t           state;
  logic [CNT_W-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             last_iter;

  // datapath
  logic                          neg_a;
  logic                          neg_b;
  logic [`MULDIV_XLEN-1:0]       mag_a;
  logic [`MULDIV_XLEN-1:0]       mag_b;
  logic                          sign_a_reg;
  logic                          sign_b_reg;
  logic                          zero_reg;
  logic [`MULDIV_XLEN-1:0]       dvsr_reg;
  logic [`MULDIV_RESULT_W-1:0]   rq_reg;
  logic [`MULDIV_RESULT_W:0]     rq_shift;
  logic [`MULDIV_XLEN+1:0]       trial;
  logic [`MULDIV_XLEN-1:0]       quot_raw;
  logic [`MULDIV_XLEN-1:0]       rem_raw;
  muldiv_result_t                result;

  //--------------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------------

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == CNT_W'(`MULDIV_ITERS - 1));

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          count <= count + 1'b1;
          if (last_iter) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // signs only count for signed divide
  assign neg_a = div_signed && req_a[`MULDIV_XLEN-1];
  assign neg_b = div_signed && req_b[`MULDIV_XLEN-1];
  assign mag_a = neg_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = neg_b ? (~req_b + 1'b1) : req_b;

  // shift rem:quot left, then trial subtract from the upper part
  // extra top bit on trial is the borrow
  assign rq_shift = {rq_reg, 1'b0};
  assign trial    = {1'b0, rq_shift[`MULDIV_RESULT_W:`MULDIV_XLEN]} - {2'b00, dvsr_reg};

  always_ff @(posedge clk) begin
    if (req_go) begin
      sign_a_reg <= neg_a;
      sign_b_reg <= neg_b;
      zero_reg   <= (req_b == '0);
      dvsr_reg   <= mag_b;
      rq_reg     <= {{`MULDIV_XLEN{1'b0}}, mag_a};
    end else if (state == CALC) begin
      if (!trial[`MULDIV_XLEN+1]) begin
        // fits, keep difference and set quotient bit
        rq_reg <= {trial[`MULDIV_XLEN-1:0], rq_shift[`MULDIV_XLEN-1:1], 1'b1};
      end else begin
        // restore, keep shifted value
        rq_reg <= rq_shift[`MULDIV_RESULT_W-1:0];
      end
    end
  end

  assign rem_raw  = rq_reg[`MULDIV_RESULT_W-1:`MULDIV_XLEN];
  assign quot_raw = rq_reg[`MULDIV_XLEN-1:0];

  // sign fix on the stored result
  // min / -1 gives 2^31 magnitude, negated back to min value, remainder 0
  // with a zero divisor the remainder already ends up as the dividend
  always_comb begin
    result.div.rem  = sign_a_reg ? (~rem_raw + 1'b1) : rem_raw;
    result.div.quot = (sign_a_reg ^ sign_b_reg) ? (~quot_raw + 1'b1) : quot_raw;
    if (zero_reg) begin
      result.div.quot = '1;
    end
  end

  assign resp_result = result;

endmodule

// File: int_mul_iterative.sv
//----------------------------------------------------------------------------
// iterative signed multiplier
// shift-and-add on operand magnitudes, one bit per cycle, sign fixed at output
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

module int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic [`MULDIV_XLEN-1:0]    req_a,
  input  logic [`MULDIV_XLEN-1:0]    req_b,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_t resp_result
);

  import muldiv_pkg::*;

  localparam int CNT_W = $clog2(`MULDIV_ITERS);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  // control
  state_t           state;
  logic [CNT_W-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             last_iter;

  // datapath
  logic                          sign_a_reg;
  logic                          sign_b_reg;
  logic [`MULDIV_XLEN-1:0]       mag_a;
  logic [`MULDIV_XLEN-1:0]       mag_b;
  logic [`MULDIV_RESULT_W-1:0]   mcand_reg;
  logic [`MULDIV_XLEN-1:0]       mplier_reg;
  logic [`MULDIV_RESULT_W-1:0]   acc_reg;
  muldiv_result_t                result;

  //--------------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------------

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == CNT_W'(`MULDIV_ITERS - 1));

  // ready only when empty, so a held result blocks new work
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // counter wraps back to zero on the last step
          count <= count + 1'b1;
          if (last_iter) begin
            state <= DONE;
          end
        end
        DONE: begin
          // hold result until the response is taken
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // magnitude datapath
  //--------------------------------------------------------------------------

  // two's complement magnitude, min value maps to 2^31 unsigned
  assign mag_a = req_a[`MULDIV_XLEN-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[`MULDIV_XLEN-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      sign_a_reg <= req_a[`MULDIV_XLEN-1];
      sign_b_reg <= req_b[`MULDIV_XLEN-1];
      mcand_reg  <= {{`MULDIV_XLEN{1'b0}}, mag_a};
      mplier_reg <= mag_b;
      acc_reg    <= '0;
    end else if (state == CALC) begin
      // add shifted multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // negative product when exactly one operand was negative
  always_comb begin
    result.product = (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 1'b1) : acc_reg;
  end

  assign resp_result = result;

endmodule

// File: muldiv_cfg.svh
//----------------------------------------------------------------------------
// muldiv configuration
// operand width and iteration count shared by the multiply/divide unit
//----------------------------------------------------------------------------

`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// operand width in bits, both sources and each half of the result
`define MULDIV_XLEN 32

// full result word, product or remainder:quotient
`define MULDIV_RESULT_W (2 * `MULDIV_XLEN)

// calc cycles per operation, one result bit per cycle
// must track the operand width for both units
`define MULDIV_ITERS `MULDIV_XLEN

// request to response latency with no contention is MULDIV_ITERS + 1
// (accept edge, ITERS calc cycles, then valid in DONE)

`endif

// File: muldiv_checker.sv
//----------------------------------------------------------------------------
// muldiv handshake checker
// response stability under stall, output state right after reset
//----------------------------------------------------------------------------

module muldiv_checker (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_rdy,
  input logic                       resp_val,
  input logic                       resp_rdy,
  input muldiv_pkg::muldiv_fn_t     resp_fn,
  input muldiv_pkg::muldiv_result_t resp_result
);

  timeunit 1ns;
  timeprecision 100ps;

  // a stalled response keeps valid, code and result
  property resp_hold_p;
    @(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_fn) && $stable(resp_result));
  endproperty

  resp_hold_a: assert property (resp_hold_p)
    else $error("response changed while stalled");

  // first cycle out of reset, both units idle
  reset_rdy_a: assert property (@(posedge clk) $fell(reset) |-> req_rdy)
    else $error("req_rdy low in the first cycle after reset");

  reset_val_a: assert property (@(posedge clk) $fell(reset) |-> !resp_val)
    else $error("resp_val high in the first cycle after reset");

endmodule

bind muldiv_top muldiv_checker checker_i (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_fn     (resp_fn),
  .resp_result (resp_result)
);

// File: muldiv_pkg.sv
//----------------------------------------------------------------------------
// muldiv package
// function codes and the shared 64-bit result word
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

package muldiv_pkg;

  // function code carried on request and response
  // FN_MUL  signed 32x32 -> 64 product
  // FN_DIV  signed divide, remainder follows dividend sign
  // FN_DIVU unsigned divide
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

  //--------------------------------------------------------------------------
  // result word
  //--------------------------------------------------------------------------

  // division view, remainder in the upper half
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] rem;
    logic [`MULDIV_XLEN-1:0] quot;
  } muldiv_div_t;

  // one word, decoded as a product or as remainder:quotient
  // which view applies depends on the function code
  typedef union packed {
    logic [`MULDIV_RESULT_W-1:0] product;
    muldiv_div_t                 div;
  } muldiv_result_t;

endpackage

// File: muldiv_router.sv
//----------------------------------------------------------------------------
// muldiv router
// steers requests by function code, round-robin on the two response streams
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

module muldiv_router (
  input  logic                       clk,
  input  logic                       reset,

  // outside request and response
  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::muldiv_fn_t     req_fn,
  input  logic [`MULDIV_XLEN-1:0]    req_a,
  input  logic [`MULDIV_XLEN-1:0]    req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_fn_t     resp_fn,
  output muldiv_pkg::muldiv_result_t resp_result,

  // multiplier
  output logic                       mul_req_val,
  input  logic                       mul_req_rdy,
  output logic [`MULDIV_XLEN-1:0]    mul_req_a,
  output logic [`MULDIV_XLEN-1:0]    mul_req_b,
  input  logic                       mul_resp_val,
  output logic                       mul_resp_rdy,
  input  muldiv_pkg::muldiv_result_t mul_resp_result,

  // divider
  output logic                       div_req_val,
  input  logic                       div_req_rdy,
  output logic [`MULDIV_XLEN-1:0]    div_req_a,
  output logic [`MULDIV_XLEN-1:0]    div_req_b,
  output logic                       div_signed,
  input  logic                       div_resp_val,
  output logic                       div_resp_rdy,
  input  muldiv_pkg::muldiv_result_t div_resp_result
);

  import muldiv_pkg::*;

  logic is_mul;
  logic div_signed_reg;
  logic prio_div;
  logic lock_val;
  logic lock_div;
  logic gnt_div;
  logic resp_go;

  //--------------------------------------------------------------------------
  // request steering
  //--------------------------------------------------------------------------

  // any code other than FN_MUL goes to the divider
  assign is_mul      = (req_fn == FN_MUL);
  assign div_signed  = (req_fn != FN_DIVU);
  assign mul_req_val = req_val && is_mul;
  assign div_req_val = req_val && !is_mul;
  assign req_rdy     = is_mul ? mul_req_rdy : div_req_rdy;
  assign mul_req_a   = req_a;
  assign mul_req_b   = req_b;
  assign div_req_a   = req_a;
  assign div_req_b   = req_b;

  // divider holds one op, so this stays valid until its response leaves
  always_ff @(posedge clk) begin
    if (div_req_val && div_req_rdy) begin
      div_signed_reg <= div_signed;
    end
  end

  //--------------------------------------------------------------------------
  // response arbitration
  //--------------------------------------------------------------------------

  // a stalled grant is locked so the payload holds steady
  assign gnt_div = lock_val ? lock_div
                            : (div_resp_val && (!mul_resp_val || prio_div));

  assign resp_val     = mul_resp_val || div_resp_val;
  assign resp_go      = resp_val && resp_rdy;
  assign mul_resp_rdy = resp_rdy && !gnt_div;
  assign div_resp_rdy = resp_rdy && gnt_div;
  assign resp_result  = gnt_div ? div_resp_result : mul_resp_result;
  assign resp_fn      = !gnt_div ? FN_MUL : (div_signed_reg ? FN_DIV : FN_DIVU);

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div <= 1'b0;
      lock_val <= 1'b0;
      lock_div <= 1'b0;
    end else begin
      // loser of this transfer gets priority next time
      if (resp_go) begin
        prio_div <= !gnt_div;
        lock_val <= 1'b0;
      end else if (resp_val) begin
        lock_val <= 1'b1;
        lock_div <= gnt_div;
      end
    end
  end

endmodule

// File: muldiv_top.sv
//----------------------------------------------------------------------------
// muldiv top level
// router plus one multiplier and one divider, two ops in flight at most
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

module muldiv_top (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::muldiv_fn_t     req_fn,
  input  logic [`MULDIV_XLEN-1:0]    req_a,
  input  logic [`MULDIV_XLEN-1:0]    req_b,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_fn_t     resp_fn,
  output muldiv_pkg::muldiv_result_t resp_result
);

  import muldiv_pkg::*;

  // multiplier side
  logic                    mul_req_val;
  logic                    mul_req_rdy;
  logic [`MULDIV_XLEN-1:0] mul_req_a;
  logic [`MULDIV_XLEN-1:0] mul_req_b;
  logic                    mul_resp_val;
  logic                    mul_resp_rdy;
  muldiv_result_t          mul_resp_result;

  // divider side
  logic                    div_req_val;
  logic                    div_req_rdy;
  logic [`MULDIV_XLEN-1:0] div_req_a;
  logic [`MULDIV_XLEN-1:0] div_req_b;
  logic                    div_signed;
  logic                    div_resp_val;
  logic                    div_resp_rdy;
  muldiv_result_t          div_resp_result;

  muldiv_router router_i (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .req_fn          (req_fn),
    .req_a           (req_a),
    .req_b           (req_b),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .resp_fn         (resp_fn),
    .resp_result     (resp_result),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .mul_req_a       (mul_req_a),
    .mul_req_b       (mul_req_b),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy),
    .mul_resp_result (mul_resp_result),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .div_req_a       (div_req_a),
    .div_req_b       (div_req_b),
    .div_signed      (div_signed),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .div_resp_result (div_resp_result)
  );

  int_mul_iterative mul_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (mul_req_a),
    .req_b       (mul_req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  int_div_iterative div_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_a       (div_req_a),
    .req_b       (div_req_b),
    .div_signed  (div_signed),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_muldiv \
  -f flist.f \
  --Mdir obj_dir -o sim_muldiv
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_muldiv
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// File: tb_muldiv.sv
//----------------------------------------------------------------------------
// muldiv testbench
// corner and random requests, reference model, in-order compare per unit
//----------------------------------------------------------------------------

`include "muldiv_cfg.svh"

module tb_muldiv;

  timeunit 1ns;
  timeprecision 100ps;

  import muldiv_pkg::*;

  localparam int XLEN          = `MULDIV_XLEN;
  localparam int N_RANDOM      = 300;
  localparam int REQ_TIMEOUT   = 200;
  localparam int RESP_TIMEOUT  = 100;
  localparam int DRAIN_TIMEOUT = 1000;

  localparam logic [31:0]     SEED     = 32'h8d65d2df;
  localparam logic [XLEN-1:0] MIN_VAL  = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_VAL  = ~MIN_VAL;
  localparam logic [XLEN-1:0] ALL_ONES = '1;
  localparam logic [XLEN-1:0] CORNERS [5] = '{'0, 1, ALL_ONES, MIN_VAL, MAX_VAL};

  // DUT ports
  logic           clk;
  logic           reset;
  logic           req_val;
  logic           req_rdy;
  muldiv_fn_t     req_fn;
  logic [XLEN-1:0] req_a;
  logic [XLEN-1:0] req_b;
  logic           resp_val;
  logic           resp_rdy;
  muldiv_fn_t     resp_fn;
  muldiv_result_t resp_result;

  integer stim_seed;
  integer rdy_seed;
  logic   rdy_random;

  // expectations per unit kept in request order
  muldiv_result_t mul_q[$];
  muldiv_result_t div_q[$];
  muldiv_fn_t     div_fn_q[$];

  muldiv_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

  //--------------------------------------------------------------------------
  // reference model and checks
  //--------------------------------------------------------------------------

  function automatic muldiv_result_t muldiv_model(input muldiv_fn_t fn,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    muldiv_result_t r;
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    r  = '0;
    if (fn == FN_MUL) begin
      r.product = sa * sb;
    end else if (b == '0) begin
      // zero divisor gives all ones and the dividend back
      r.div.quot = ALL_ONES;
      r.div.rem  = a;
    end else if (fn == FN_DIVU) begin
      r.div.quot = a / b;
      r.div.rem  = a % b;
    end else if (a == MIN_VAL && b == ALL_ONES) begin
      r.div.quot = MIN_VAL;
      r.div.rem  = '0;
    end else begin
      // truncating divide with the remainder keeping the dividend sign
      r.div.quot = XLEN'(sa / sb);
      r.div.rem  = XLEN'(sa % sb);
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_fn(input string name, input muldiv_fn_t got, input muldiv_fn_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %s, expected %s",
                          $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic check_result(input string name, input muldiv_result_t got,
      input muldiv_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("Error at %0t: resp_val latency is %0d, expected %0d",
                          $time, got, exp));
    end
  endtask

  //--------------------------------------------------------------------------
  // clock, back-pressure, monitors
  //--------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // resp_rdy low about one cycle in four while random mode is on
  initial begin
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      if (rdy_random) begin
        resp_rdy <= (($random(rdy_seed) & 3) != 0);
      end else begin
        resp_rdy <= 1'b1;
      end
    end
  end

  // expectation for every accepted request
  always @(posedge clk) begin
    if (!reset && req_val && req_rdy) begin
      if (req_fn == FN_MUL) begin
        mul_q.push_back(muldiv_model(req_fn, req_a, req_b));
      end else begin
        div_q.push_back(muldiv_model(req_fn, req_a, req_b));
        div_fn_q.push_back(req_fn);
      end
    end
  end

  // compare on every response transfer against the queue named by resp_fn
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (resp_fn == FN_MUL) begin
        if (mul_q.size() == 0) begin
          abort_run("multiplier response arrived with no request pending");
        end else begin
          check_result("resp_result", resp_result, mul_q.pop_front());
        end
      end else if (div_q.size() == 0) begin
        abort_run("divider response arrived with no request pending");
      end else begin
        check_fn("resp_fn", resp_fn, div_fn_q.pop_front());
        check_result("resp_result", resp_result, div_q.pop_front());
      end
    end
  end

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  // called on a rising edge and returns on the edge of the transfer
  task automatic send_req(input muldiv_fn_t fn, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b);
    int waited;
    waited = 0;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(posedge clk);
    while (!req_rdy) begin
      if (waited >= REQ_TIMEOUT) begin
        abort_run("timeout, request was never accepted");
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    req_val <= 1'b0;
  endtask

  // queue sizes sampled on the falling edge between monitor updates
  task automatic drain_queues();
    int waited;
    waited = 0;
    @(negedge clk);
    while (mul_q.size() != 0 || div_q.size() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        abort_run("timeout, responses still outstanding");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    @(posedge clk);
  endtask

  initial begin
    muldiv_fn_t      fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     pick;
    int              cycles;
    stim_seed  = SEED;
    rdy_seed   = SEED;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = FN_MUL;
    req_a      = '0;
    req_b      = '0;
    rdy_random = 1'b0;
    repeat (4) @(posedge clk);
    reset      <= 1'b0;
    rdy_random <= 1'b1;
    @(posedge clk);

    // corner operands with all three functions interleaved
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_req(FN_MUL, CORNERS[i], CORNERS[j]);
        send_req(FN_DIV, CORNERS[i], CORNERS[j]);
        send_req(FN_DIVU, CORNERS[i], CORNERS[j]);
      end
    end

    // random mix with some small and some zero divisors
    for (int n = 0; n < N_RANDOM; n++) begin
      pick = $random(stim_seed);
      a    = $random(stim_seed);
      b    = $random(stim_seed);
      fn   = (pick[1:0] == 2'd1) ? FN_DIV : (pick[1:0] == 2'd2) ? FN_DIVU : FN_MUL;
      if (pick[4:2] == 3'd0) begin
        b = b & XLEN'(8'hff);
      end
      if (pick[8:5] == 4'd0) begin
        b = '0;
      end
      send_req(fn, a, b);
    end
    drain_queues();

    // isolated multiply without back-pressure
    rdy_random <= 1'b0;
    drain_queues();
    a = $random(stim_seed);
    b = $random(stim_seed);
    send_req(FN_MUL, a, b);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!resp_val && cycles < RESP_TIMEOUT);
    if (!resp_val) begin
      abort_run("timeout, isolated multiply response never arrived");
    end else begin
      check_latency(cycles, `MULDIV_ITERS + 1);
    end
    drain_queues();

    $display(">>> PASS");
    $finish;
  end

endmodule
